/* design/fc_settings.svh */
// Widths, depths and run length shared by the filter-condition config loader
// Include this ahead of the package and any module that sizes on these values

`ifndef FC_SETTINGS_SVH
`define FC_SETTINGS_SVH

`define FC_DATA_W       32
`define FC_ADDR_W       16
`define FC_SHIFT_W      4
`define FC_SEQ_LEN      16
`define FC_FIELDS       4

`define FC_RESP_DEPTH   16
`define FC_CFG_DEPTH    4
`define FC_CFG_THRESH   2

`define FC_CU_W         2
`define FC_BUNDLE_W     2
`define FC_LANE_W       2
`define FC_BUFFER_W     2
`define FC_ENGINE_W     3
`define FC_MODULE_W     2
`define FC_CREDIT_W     5

`endif

/* design/filter_cond_pkg.sv */
// Packet, route and configuration types for the filter-condition config loader
// Modules import this in their body and use scoped names on their ports

`default_nettype none

`include "fc_settings.svh"

package filter_cond_pkg;

    // ------------------------------
    // Enums
    // ------------------------------
    typedef enum logic [2:0] {
        CLASS_INVALID      = 3'd0,
        CLASS_CU_SETUP     = 3'd1,
        CLASS_ENGINE_SETUP = 3'd2,
        CLASS_DATA         = 3'd3
    } buffer_class_e;

    typedef enum logic [2:0] {
        FILTER_NOP, FILTER_GT, FILTER_LT, FILTER_EQ,
        FILTER_NE, FILTER_GE, FILTER_LE, FILTER_MASK
    } filter_op_e;

    // ------------------------------
    // Packets
    // ------------------------------
    typedef struct packed {
        logic                   valid;
        buffer_class_e          buf_class;
        logic [`FC_ADDR_W-1:0]  offset;
        logic [`FC_SHIFT_W-1:0] shift;
        logic [`FC_DATA_W-1:0]  data;
    } mem_packet_t;

    // What survives the class and window filter
    typedef struct packed {
        logic [`FC_ADDR_W-1:0] seq;
        logic [`FC_DATA_W-1:0] data;
    } resp_word_t;

    // ------------------------------
    // Configuration
    // ------------------------------
    typedef struct packed {
        logic [`FC_CU_W-1:0]     id_cu;
        logic [`FC_BUNDLE_W-1:0] id_bundle;
        logic [`FC_LANE_W-1:0]   id_lane;
        logic [`FC_BUFFER_W-1:0] id_buffer;
        logic [`FC_ENGINE_W-1:0] id_engine;
        logic [`FC_MODULE_W-1:0] id_module;
    } filter_route_t;

    typedef struct packed {
        logic break_flag;
        logic break_pass;
        logic filter_post;
        logic filter_pass;
        logic continue_flag;
        logic ternary_flag;
        logic conditional_flag;
    } cond_flags_t;

    typedef struct packed {
        filter_op_e                         operation;
        logic [`FC_FIELDS-1:0]              filter_mask;
        logic [`FC_FIELDS-1:0]              const_mask;
        logic [`FC_DATA_W-1:0]              const_value;
        logic [`FC_FIELDS*`FC_FIELDS-1:0]   ops_mask;
        cond_flags_t                        flags;
        filter_route_t                      route_if;
        filter_route_t                      route_else;
    } cond_config_t;

endpackage

`default_nettype wire

/* design/credit_fifo.sv */
// Synchronous first-word fall-through FIFO for any packed payload type
// pop_data shows the head while not empty; pop only when not empty
// above_thresh lets a producer upstream stop before the FIFO fills

`timescale 1ns/1ns
`default_nettype none

module credit_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  depth     = 4,
    parameter int  thresh    = 2
) (
    input  wire logic     ap_clk,
    input  wire logic     rst_n,
    input  wire logic     push,
    input  wire payload_t push_data,
    input  wire logic     pop,
    output payload_t      pop_data,
    output logic          empty,
    output logic          above_thresh
);

    localparam int ptr_w = $clog2(depth);
    localparam int cnt_w = $clog2(depth + 1);

    payload_t               mem [depth];
    logic [ptr_w-1:0]       wr_ptr;
    logic [ptr_w-1:0]       rd_ptr;
    logic [cnt_w-1:0]       count;
    logic                   full;

    // ------------------------------
    // Storage
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // Head of queue straight out of the array
    assign pop_data = mem[rd_ptr];

    // ------------------------------
    // Pointers and count
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + cnt_w'(push) - cnt_w'(pop);
        end
    end

    assign empty        = (count == '0);
    assign full         = (count == cnt_w'(depth));
    assign above_thresh = (count >= cnt_w'(thresh));

    // Producers rely on credits or the threshold to stay clear of these
    a_no_overflow: assert property (@(posedge ap_clk) disable iff (!rst_n)
        !(push && full))
        else $error("credit_fifo: push while full");

    a_no_underflow: assert property (@(posedge ap_clk) disable iff (!rst_n)
        !(pop && empty))
        else $error("credit_fifo: pop while empty");

endmodule

`default_nettype wire

/* design/setup_ingress.sv */
// Front end of the config loader: registers memory responses, keeps setup
// words inside this engine's sequence window and returns ingress credits
// One credit goes back per dropped packet and per word popped downstream

`timescale 1ns/1ns
`default_nettype none

`include "fc_settings.svh"

module setup_ingress #(
    parameter int id_relative = 0
) (
    input  wire logic                        ap_clk,
    input  wire logic                        rst_n,
    input  wire filter_cond_pkg::mem_packet_t pkt_in,
    input  wire logic                        resp_pop,
    output logic                             word_push,
    output filter_cond_pkg::resp_word_t      word_data,
    output logic                             resp_credit
);

    import filter_cond_pkg::*;

    localparam logic [`FC_ADDR_W-1:0] seq_min = `FC_ADDR_W'(id_relative * `FC_SEQ_LEN);

    mem_packet_t              pkt_q;
    logic [`FC_ADDR_W-1:0]    pkt_seq;
    logic [`FC_ADDR_W-1:0]    seq_off;
    logic                     accept;
    logic                     drop;
    logic [`FC_CREDIT_W-1:0]  credit_pend;
    logic [`FC_CREDIT_W-1:0]  credit_sum;

    // ------------------------------
    // Input register
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (!rst_n) begin
            pkt_q.valid <= 1'b0;
        end else begin
            pkt_q.valid <= pkt_in.valid;
        end
        pkt_q.buf_class <= pkt_in.buf_class;
        pkt_q.offset    <= pkt_in.offset;
        pkt_q.shift     <= pkt_in.shift;
        pkt_q.data      <= pkt_in.data;
    end

    // Window test by unsigned distance from seq_min, wraps below it
    assign pkt_seq = pkt_q.offset >> pkt_q.shift;
    assign seq_off = pkt_seq - seq_min;
    assign accept  = ((pkt_q.buf_class == CLASS_CU_SETUP) ||
                      (pkt_q.buf_class == CLASS_ENGINE_SETUP)) &&
                     (seq_off < `FC_ADDR_W'(`FC_SEQ_LEN));

    assign word_push      = pkt_q.valid && accept;
    assign drop           = pkt_q.valid && !accept;
    assign word_data.seq  = pkt_seq;
    assign word_data.data = pkt_q.data;

    // ------------------------------
    // Credit return
    // ------------------------------
    // Owed credits drain one per cycle, so a drop and a pop together
    // spill one into the next cycle
    assign credit_sum = credit_pend + `FC_CREDIT_W'(drop) + `FC_CREDIT_W'(resp_pop);

    always_ff @(posedge ap_clk) begin
        if (!rst_n) begin
            credit_pend <= '0;
            resp_credit <= 1'b0;
        end else begin
            resp_credit <= (credit_sum != '0);
            credit_pend <= credit_sum - `FC_CREDIT_W'(credit_sum != '0);
        end
    end

    // Upstream never holds more than a FIFO's worth, so the backlog is bounded
    a_pend_bounded: assert property (@(posedge ap_clk) disable iff (!rst_n)
        credit_pend <= `FC_CREDIT_W'(`FC_RESP_DEPTH))
        else $error("setup_ingress: credit backlog beyond response depth");

endmodule

`default_nettype wire

/* design/cond_config_assembler.sv */
// Builds one filter-condition configuration from a run of setup words
// A run starts on index seq_min while idle and covers FC_SEQ_LEN words;
// word k writes field k of the held configuration, which is pushed one
// cycle after the last word. Fields not written keep their old value

`timescale 1ns/1ns
`default_nettype none

`include "fc_settings.svh"

module cond_config_assembler #(
    parameter int id_relative = 0
) (
    input  wire logic                         ap_clk,
    input  wire logic                         rst_n,
    input  wire logic                         resp_empty,
    input  wire filter_cond_pkg::resp_word_t  resp_data,
    output logic                              resp_pop,
    input  wire logic                         cfg_full,
    output logic                              cfg_push,
    output filter_cond_pkg::cond_config_t     cfg_data
);

    import filter_cond_pkg::*;

    localparam logic [`FC_ADDR_W-1:0] seq_min = `FC_ADDR_W'(id_relative * `FC_SEQ_LEN);

    // Bit offsets inside the route words
    localparam int bundle_lo   = `FC_CU_W;
    localparam int lane_lo     = bundle_lo + `FC_BUNDLE_W;
    localparam int buffer_lo   = lane_lo + `FC_LANE_W;
    localparam int if_mod_lo   = `FC_ENGINE_W;
    localparam int else_eng_lo = if_mod_lo + `FC_MODULE_W;
    localparam int else_mod_lo = else_eng_lo + `FC_ENGINE_W;

    logic [`FC_SEQ_LEN-1:0]  pos;
    logic [`FC_SEQ_LEN-1:0]  word_sel;
    logic                    run_start;
    logic [`FC_DATA_W-1:0]   word;
    cond_config_t            cfg_q;

    // cu, bundle, lane and buffer ids from the low bits of a word
    function automatic filter_route_t set_ids(input filter_route_t route,
                                              input logic [`FC_DATA_W-1:0] d);
        filter_route_t r;
        r           = route;
        r.id_cu     = d[0 +: `FC_CU_W];
        r.id_bundle = d[bundle_lo +: `FC_BUNDLE_W];
        r.id_lane   = d[lane_lo +: `FC_LANE_W];
        r.id_buffer = d[buffer_lo +: `FC_BUFFER_W];
        return r;
    endfunction

    // ------------------------------
    // Run position
    // ------------------------------
    // pos holds the next expected word, all zero while idle
    assign run_start = (pos == '0) && (resp_data.seq == seq_min);
    assign word_sel  = run_start ? `FC_SEQ_LEN'(1) : pos;
    assign word      = resp_data.data;

    // Hold off while a finished config goes out or the config FIFO backs up
    assign resp_pop = !resp_empty && !cfg_full && !cfg_push;

    always_ff @(posedge ap_clk) begin
        if (!rst_n) begin
            pos      <= '0;
            cfg_push <= 1'b0;
        end else begin
            cfg_push <= resp_pop && word_sel[`FC_SEQ_LEN-1];
            if (resp_pop) begin
                // Stray word while idle leaves word_sel at zero
                pos <= word_sel << 1;
            end
        end
    end

    // ------------------------------
    // Field decode
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (resp_pop) begin
            case (1'b1)
                word_sel[0]: cfg_q.operation   <= filter_op_e'(word[$bits(filter_op_e)-1:0]);
                word_sel[1]: cfg_q.filter_mask <= word[`FC_FIELDS-1:0];
                word_sel[2]: cfg_q.const_mask  <= word[`FC_FIELDS-1:0];
                word_sel[3]: cfg_q.const_value <= word;
                word_sel[4]: cfg_q.ops_mask    <= word[`FC_FIELDS*`FC_FIELDS-1:0];
                word_sel[5]: begin
                    cfg_q.flags.break_flag       <= word[0];
                    cfg_q.flags.break_pass       <= word[1];
                    cfg_q.flags.filter_post      <= word[2];
                    cfg_q.flags.filter_pass      <= word[3];
                    cfg_q.flags.continue_flag    <= word[4];
                    cfg_q.flags.ternary_flag     <= word[5];
                    cfg_q.flags.conditional_flag <= word[6];
                end
                word_sel[6]: cfg_q.route_if   <= set_ids(cfg_q.route_if, word);
                word_sel[7]: cfg_q.route_else <= set_ids(cfg_q.route_else, word);
                word_sel[8]: begin
                    cfg_q.route_if.id_engine   <= word[0 +: `FC_ENGINE_W];
                    cfg_q.route_if.id_module   <= word[if_mod_lo +: `FC_MODULE_W];
                    cfg_q.route_else.id_engine <= word[else_eng_lo +: `FC_ENGINE_W];
                    cfg_q.route_else.id_module <= word[else_mod_lo +: `FC_MODULE_W];
                end
                // Words 9 to 15 are reserved
                default: ;
            endcase
        end
    end

    assign cfg_data = cfg_q;

    a_pos_onehot: assert property (@(posedge ap_clk) disable iff (!rst_n)
        $onehot0(pos))
        else $error("cond_config_assembler: more than one run position set");

endmodule

`default_nettype wire

/* design/config_egress.sv */
// Output stage: pops one finished configuration per downstream credit
// cfg_out and cfg_out_valid are registered, one cycle after the pop

`timescale 1ns/1ns
`default_nettype none

`include "fc_settings.svh"

module config_egress (
    input  wire logic                          ap_clk,
    input  wire logic                          rst_n,
    input  wire logic                          cfg_credit,
    input  wire logic                          cfg_empty,
    input  wire filter_cond_pkg::cond_config_t cfg_data,
    output logic                               cfg_pop,
    output logic                               cfg_out_valid,
    output filter_cond_pkg::cond_config_t      cfg_out
);

    logic [`FC_CREDIT_W-1:0] credit_cnt;

    // Starts with no credits after reset
    assign cfg_pop = (credit_cnt != '0) && !cfg_empty;

    always_ff @(posedge ap_clk) begin
        if (!rst_n) begin
            credit_cnt    <= '0;
            cfg_out_valid <= 1'b0;
        end else begin
            credit_cnt    <= credit_cnt + `FC_CREDIT_W'(cfg_credit) - `FC_CREDIT_W'(cfg_pop);
            cfg_out_valid <= cfg_pop;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (cfg_pop) begin
            cfg_out <= cfg_data;
        end
    end

    a_credit_no_wrap: assert property (@(posedge ap_clk) disable iff (!rst_n)
        !((&credit_cnt) && cfg_credit && !cfg_pop))
        else $error("config_egress: credit counter wrapped");

endmodule

`default_nettype wire

/* design/filter_cond_config_top.sv */
// Top of the filter-condition config loader for one engine
// Setup responses enter on pkt_in under ingress credits; configurations
// leave on cfg_out under downstream credits

`timescale 1ns/1ns
`default_nettype none

`include "fc_settings.svh"

module filter_cond_config_top #(
    parameter int id_relative = 0
) (
    input  wire logic                         ap_clk,
    input  wire logic                         rst_n,
    input  wire filter_cond_pkg::mem_packet_t pkt_in,
    output logic                              resp_credit,
    input  wire logic                         cfg_credit,
    output logic                              cfg_out_valid,
    output filter_cond_pkg::cond_config_t     cfg_out
);

    import filter_cond_pkg::*;

    logic          resp_push;
    resp_word_t    resp_in;
    logic          resp_pop;
    resp_word_t    resp_head;
    logic          resp_empty;

    logic          cfg_push;
    cond_config_t  cfg_in;
    logic          cfg_pop;
    cond_config_t  cfg_head;
    logic          cfg_empty;
    logic          cfg_above;

    // ------------------------------
    // Ingress and response FIFO
    // ------------------------------
    setup_ingress #(.id_relative(id_relative)) u_setup_ingress (
        .ap_clk      (ap_clk),
        .rst_n       (rst_n),
        .pkt_in      (pkt_in),
        .resp_pop    (resp_pop),
        .word_push   (resp_push),
        .word_data   (resp_in),
        .resp_credit (resp_credit)
    );

    // Credits bound occupancy here, threshold flag left open
    credit_fifo #(
        .payload_t (resp_word_t),
        .depth     (`FC_RESP_DEPTH),
        .thresh    (`FC_RESP_DEPTH)
    ) u_resp_fifo (
        .ap_clk       (ap_clk),
        .rst_n        (rst_n),
        .push         (resp_push),
        .push_data    (resp_in),
        .pop          (resp_pop),
        .pop_data     (resp_head),
        .empty        (resp_empty),
        .above_thresh ()
    );

    // ------------------------------
    // Assembly and egress
    // ------------------------------
    cond_config_assembler #(.id_relative(id_relative)) u_assembler (
        .ap_clk     (ap_clk),
        .rst_n      (rst_n),
        .resp_empty (resp_empty),
        .resp_data  (resp_head),
        .resp_pop   (resp_pop),
        .cfg_full   (cfg_above),
        .cfg_push   (cfg_push),
        .cfg_data   (cfg_in)
    );

    credit_fifo #(
        .payload_t (cond_config_t),
        .depth     (`FC_CFG_DEPTH),
        .thresh    (`FC_CFG_THRESH)
    ) u_cfg_fifo (
        .ap_clk       (ap_clk),
        .rst_n        (rst_n),
        .push         (cfg_push),
        .push_data    (cfg_in),
        .pop          (cfg_pop),
        .pop_data     (cfg_head),
        .empty        (cfg_empty),
        .above_thresh (cfg_above)
    );

    config_egress u_egress (
        .ap_clk        (ap_clk),
        .rst_n         (rst_n),
        .cfg_credit    (cfg_credit),
        .cfg_empty     (cfg_empty),
        .cfg_data      (cfg_head),
        .cfg_pop       (cfg_pop),
        .cfg_out_valid (cfg_out_valid),
        .cfg_out       (cfg_out)
    );

endmodule

`default_nettype wire

/* tests/tb_filter_cond_config.sv */
// Testbench for the filter-condition config loader, engine window 16 to 31
// Sends setup runs from a table under ingress credits, grants egress credits
// and compares every configuration with a decode of the same table

`timescale 1ns/1ns
`default_nettype none

`include "fc_settings.svh"

module tb_filter_cond_config;

    import filter_cond_pkg::*;

    localparam int seq_min = 1 * `FC_SEQ_LEN;

    logic          ap_clk = 1'b0;
    logic          rst_n;
    mem_packet_t   pkt_in;
    logic          resp_credit;
    logic          cfg_credit;
    logic          cfg_out_valid;
    cond_config_t  cfg_out;

    // Stimulus table, expected and received configurations
    mem_packet_t   stim_rows[$];
    int            row_test[$];
    cond_config_t  exp_cfg[$];
    int            exp_test[$];
    cond_config_t  rx_cfg[$];

    int      pkts_sent = 0;
    int      credits_returned = 0;
    int      grant_budget = 0;
    int      valid_in_hold = 0;
    logic    holding = 1'b0;
    logic    table_ready = 1'b0;
    int      checks_run = 0;
    int      error_count = 0;
    int      err_base = 0;
    integer  seed = 32'hf260_29ee;
    string   test_names [1:5] = '{"engine run, shift 0", "cu run, shift 2",
                                  "dropped and stray words", "three runs held",
                                  "credit return"};

    filter_cond_config_top #(.id_relative(1)) u_filter_cond_config_top (
        .ap_clk        (ap_clk),
        .rst_n         (rst_n),
        .pkt_in        (pkt_in),
        .resp_credit   (resp_credit),
        .cfg_credit    (cfg_credit),
        .cfg_out_valid (cfg_out_valid),
        .cfg_out       (cfg_out)
    );

    always #50 ap_clk = ~ap_clk;

    // ------------------------------
    // Table and reference decode
    // ------------------------------
    task automatic add_row(input int test, input buffer_class_e cls, input int seq,
                           input int sh, input logic [`FC_DATA_W-1:0] d);
        mem_packet_t p;
        p.valid     = 1'b1;
        p.buf_class = cls;
        p.offset    = `FC_ADDR_W'(seq << sh);
        p.shift     = `FC_SHIFT_W'(sh);
        p.data      = d;
        stim_rows.push_back(p);
        row_test.push_back(test);
    endtask

    // Full run of FC_SEQ_LEN words starting at seq_min
    task automatic add_run(input int test, input buffer_class_e cls, input int sh,
                           input logic [`FC_DATA_W-1:0] base);
        int k;
        for (k = 0; k < `FC_SEQ_LEN; k++) begin
            add_row(test, cls, seq_min + k, sh, base + `FC_DATA_W'(k) * 32'h1935_7ae1);
        end
    endtask

    // Word k of a run writes field k
    function automatic cond_config_t decode_word(input cond_config_t c, input int k,
                                                 input logic [`FC_DATA_W-1:0] d);
        cond_config_t r;
        r = c;
        case (k)
            0: r.operation   = filter_op_e'(d[2:0]);
            1: r.filter_mask = d[3:0];
            2: r.const_mask  = d[3:0];
            3: r.const_value = d;
            4: r.ops_mask    = d[15:0];
            // break sits in the top bit of the flag struct
            5: r.flags = {d[0], d[1], d[2], d[3], d[4], d[5], d[6]};
            6: begin
                r.route_if.id_cu     = d[1:0];
                r.route_if.id_bundle = d[3:2];
                r.route_if.id_lane   = d[5:4];
                r.route_if.id_buffer = d[7:6];
            end
            7: begin
                r.route_else.id_cu     = d[1:0];
                r.route_else.id_bundle = d[3:2];
                r.route_else.id_lane   = d[5:4];
                r.route_else.id_buffer = d[7:6];
            end
            8: begin
                r.route_if.id_engine   = d[2:0];
                r.route_if.id_module   = d[4:3];
                r.route_else.id_engine = d[7:5];
                r.route_else.id_module = d[9:8];
            end
            default: ;
        endcase
        return r;
    endfunction

    task automatic build_expected();
        cond_config_t cfg;
        int i;
        int seq;
        int pos;
        logic cls_ok;
        cfg = '0;
        pos = -1;
        for (i = 0; i < stim_rows.size(); i++) begin
            seq    = int'(stim_rows[i].offset >> stim_rows[i].shift);
            cls_ok = (stim_rows[i].buf_class == CLASS_CU_SETUP) ||
                     (stim_rows[i].buf_class == CLASS_ENGINE_SETUP);
            if (cls_ok && seq >= seq_min && seq < seq_min + `FC_SEQ_LEN) begin
                if (pos < 0 && seq == seq_min) begin
                    pos = 0;
                end
                if (pos >= 0) begin
                    cfg = decode_word(cfg, pos, stim_rows[i].data);
                    if (pos == `FC_SEQ_LEN - 1) begin
                        exp_cfg.push_back(cfg);
                        exp_test.push_back(row_test[i]);
                        pos = -1;
                    end else begin
                        pos = pos + 1;
                    end
                end
            end
        end
    endtask

    function automatic int exp_upto(input int t);
        int n;
        n = 0;
        foreach (exp_test[i]) begin
            if (exp_test[i] <= t) begin
                n++;
            end
        end
        return n;
    endfunction

    // ------------------------------
    // Compare tasks
    // ------------------------------
    task automatic check_count(input int got, input int exp, input string what);
        checks_run++;
        if (got != exp) begin
            error_count++;
            $display("CHECK FAILED at %0t: %s, got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_config(input cond_config_t got, input cond_config_t exp,
                                input string what);
        checks_run++;
        if (got !== exp) begin
            error_count++;
            $display("CHECK FAILED at %0t: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic report_test(input int t);
        int i;
        check_count(rx_cfg.size(), exp_upto(t), $sformatf("test %0d configuration count", t));
        for (i = 0; i < exp_cfg.size(); i++) begin
            if (exp_test[i] == t && i < rx_cfg.size()) begin
                check_config(rx_cfg[i], exp_cfg[i], $sformatf("test %0d config %0d", t, i));
            end
        end
        $display("test %0d (%s): %0d errors", t, test_names[t], error_count - err_base);
    endtask

    // ------------------------------
    // Driving and waiting
    // ------------------------------
    // Called on a rising edge, returns on a rising edge
    task automatic send_rows(input int test);
        int i;
        for (i = 0; i < stim_rows.size(); i++) begin
            if (row_test[i] == test) begin
                while (pkts_sent - credits_returned >= `FC_RESP_DEPTH) begin
                    pkt_in.valid <= 1'b0;
                    @(posedge ap_clk);
                end
                pkt_in    <= stim_rows[i];
                pkts_sent = pkts_sent + 1;
                @(posedge ap_clk);
            end
        end
        pkt_in.valid <= 1'b0;
    endtask

    task automatic wait_drained(input int n_cfg);
        while (rx_cfg.size() < n_cfg || credits_returned < pkts_sent) begin
            @(posedge ap_clk);
        end
    endtask

    always @(posedge ap_clk) begin
        if (rst_n && resp_credit) begin
            credits_returned <= credits_returned + 1;
        end
        if (rst_n && cfg_out_valid) begin
            rx_cfg.push_back(cfg_out);
            if (holding) begin
                valid_in_hold <= valid_in_hold + 1;
            end
        end
    end

    // Egress grants with random gaps, never beyond the budget
    initial begin : grant_driver
        int given;
        int gap;
        given      = 0;
        gap        = 0;
        cfg_credit = 1'b0;
        forever begin
            @(posedge ap_clk);
            if (gap > 0) begin
                gap--;
                cfg_credit <= 1'b0;
            end else if (given < grant_budget) begin
                cfg_credit <= 1'b1;
                given++;
                gap = {$random(seed)} % 4;
            end else begin
                cfg_credit <= 1'b0;
            end
        end
    end

    initial begin : watchdog
        int cycles;
        int limit;
        wait (table_ready);
        limit  = stim_rows.size() * 40 + 200;
        cycles = 0;
        while (cycles < limit) begin
            @(posedge ap_clk);
            cycles++;
        end
        $display("timeout: configurations did not arrive");
        $display("tests failed");
        $finish;
    end

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial begin : main
        int t;
        rst_n  = 1'b0;
        pkt_in = '0;

        add_run(1, CLASS_ENGINE_SETUP, 0, 32'h1234_5671);
        add_run(2, CLASS_CU_SETUP, 2, 32'h8bad_f00d);
        // Wrong class, outside the window, then a stray mid-run index
        add_row(3, CLASS_DATA, seq_min, 0, 32'h0000_0007);
        add_row(3, CLASS_DATA, seq_min + 4, 0, 32'h0000_03ff);
        add_row(3, CLASS_CU_SETUP, seq_min - 1, 0, 32'h0000_0005);
        add_row(3, CLASS_ENGINE_SETUP, seq_min + `FC_SEQ_LEN, 1, 32'h0000_0006);
        add_row(3, CLASS_INVALID, seq_min, 0, 32'h0000_0001);
        add_row(3, CLASS_CU_SETUP, seq_min + 4, 0, 32'hffff_ffff);
        add_run(3, CLASS_ENGINE_SETUP, 1, 32'h5a5a_0f0f);
        add_run(4, CLASS_ENGINE_SETUP, 0, 32'h3c3c_0001);
        add_run(4, CLASS_CU_SETUP, 0, 32'hc3c3_1002);
        add_run(4, CLASS_ENGINE_SETUP, 3, 32'h0f0f_2003);
        build_expected();
        table_ready = 1'b1;

        repeat (5) @(posedge ap_clk);
        rst_n <= 1'b1;
        @(posedge ap_clk);

        for (t = 1; t <= 3; t++) begin
            err_base     = error_count;
            grant_budget = grant_budget + exp_upto(t) - exp_upto(t - 1);
            send_rows(t);
            wait_drained(exp_upto(t));
            report_test(t);
        end

        // No grants until the response FIFO has backed up
        err_base = error_count;
        holding  = 1'b1;
        send_rows(4);
        while (pkts_sent - credits_returned != `FC_RESP_DEPTH) begin
            @(posedge ap_clk);
        end
        repeat (4) @(posedge ap_clk);
        holding = 1'b0;
        check_count(valid_in_hold, 0, "cfg_out_valid pulses without egress credits");
        grant_budget = grant_budget + exp_upto(4) - exp_upto(3);
        wait_drained(exp_upto(4));
        report_test(4);

        err_base = error_count;
        check_count(credits_returned, pkts_sent, "resp_credit pulses against packets sent");
        report_test(5);

        $display("checks: %0d, errors: %0d", checks_run, error_count);
        if (error_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
+incdir+design
design/filter_cond_pkg.sv
design/credit_fifo.sv
design/setup_ingress.sv
design/cond_config_assembler.sv
design/config_egress.sv
design/filter_cond_config_top.sv
tests/tb_filter_cond_config.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f \
    --top-module tb_filter_cond_config -Mdir obj_dir \
    && { sim_out="$(./obj_dir/Vtb_filter_cond_config)"; echo "$sim_out"; \
         grep -qx "all tests passed" <<< "$sim_out"; } \
    && echo "simulation passed" \
    || { echo "simulation did not pass"; exit 1; }
